/* rtl/dcache_control.sv */
module dcache_control (
	input logic clk,
	input logic rst_n,
	input logic req,
	input logic pipe_write,
	input logic hit,
	input logic victim_dirty,
	input logic pmem_resp,
	output logic accept,
	output logic array_read,
	output logic store,
	output logic fill,
	output logic lru_touch,
	output logic done,
	output dcache_ctrl_pkg::pmem_addr_sel_t addr_sel,
	output logic pmem_read,
	output logic pmem_write
);
	import dcache_ctrl_pkg::*;

	dcache_state_t state;
	dcache_state_t next_state;
	logic filled;
	logic start_read;
	logic start_write;

	always_comb begin
		next_state = state;
		accept = 1'b0;
		array_read = 1'b0;
		store = 1'b0;
		fill = 1'b0;
		lru_touch = 1'b0;
		done = 1'b0;
		addr_sel = addr_req_line;
		start_read = 1'b0;
		start_write = 1'b0;
		case (state)
			st_idle: begin
				if (req) begin
					accept = 1'b1;
					array_read = 1'b1;
					next_state = st_lookup;
				end
			end
			st_lookup: begin
				if (hit) begin
					done = 1'b1;
					lru_touch = 1'b1;
					store = pipe_write;
					next_state = st_done;
				end else if (victim_dirty) begin
					start_write = 1'b1;
					next_state = st_writeback;
				end else begin
					start_read = 1'b1;
					next_state = st_fill;
				end
			end
			st_writeback: begin
				addr_sel = addr_victim_line;
				if (pmem_resp) begin
					start_read = 1'b1;
					next_state = st_fill;
				end
			end
			st_fill: begin
				// Line written last cycle, read it back for the retry.
				if (filled) begin
					array_read = 1'b1;
					next_state = st_lookup;
				end else if (pmem_resp) begin
					fill = 1'b1;
				end
			end
			st_done: next_state = st_idle; // Response cycle.
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			filled <= 1'b0;
			pmem_read <= 1'b0;
			pmem_write <= 1'b0;
		end else begin
			state <= next_state;
			filled <= fill;
			pmem_read <= start_read; // Strobe in the first cycle of the state.
			pmem_write <= start_write;
		end
	end

endmodule : dcache_control

/* rtl/dcache_ctrl_pkg.sv */
package dcache_ctrl_pkg;

	// Miss controller states.
	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_writeback, // Victim line going out.
		st_fill,      // Requested line coming in.
		st_done
	} dcache_state_t;

	// Source of the line address on the memory port.
	typedef enum logic {
		addr_req_line,
		addr_victim_line
	} pmem_addr_sel_t;

endpackage : dcache_ctrl_pkg

/* rtl/dcache_req_decode.sv */
module dcache_req_decode #(
	parameter int s_offset = 5,
	parameter int s_index = 3,
	localparam int s_tag = 32 - s_offset - s_index,
	localparam int s_mask = 2**s_offset,
	localparam int s_line = 8 * s_mask
) (
	input logic clk,
	input logic rst_n,
	input logic accept,
	input logic req_write,
	input rv32_bus_pkg::rv32_word_t req_address,
	input rv32_bus_pkg::rv32_word_t req_wdata,
	input rv32_bus_pkg::rv32_mask_t req_byte_enable,
	output logic [s_index-1:0] rindex,
	output logic [s_index-1:0] pipe_index,
	output logic [s_tag-1:0] pipe_tag,
	output logic [s_offset-3:0] pipe_word_sel,
	output logic pipe_write,
	output logic [s_line-1:0] line_wdata,
	output logic [s_mask-1:0] line_byte_enable
);
	import rv32_bus_pkg::*;

	localparam int s_words = s_mask / 4;

	rv32_word_t pipe_wdata;
	rv32_mask_t pipe_mask;

	// New index goes straight to the arrays in the request cycle.
	assign rindex = accept ? req_address[s_offset +: s_index] : pipe_index;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pipe_write <= 1'b0;
		end else if (accept) begin
			pipe_write <= req_write;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pipe_index <= req_address[s_offset +: s_index];
			pipe_tag <= req_address[31 -: s_tag];
			pipe_word_sel <= req_address[2 +: s_offset-2];
			pipe_wdata <= req_wdata;
			pipe_mask <= req_byte_enable;
		end
	end

	// Same word in every slot, mask picks the one that lands.
	assign line_wdata = {s_words{pipe_wdata}};
	assign line_byte_enable = {{(s_mask-4){1'b0}}, pipe_mask} << {pipe_word_sel, 2'b00};

endmodule : dcache_req_decode

/* rtl/dcache_result.sv */
module dcache_result #(
	parameter int s_offset = 5,
	parameter int s_index = 3,
	localparam int s_tag = 32 - s_offset - s_index,
	localparam int s_line = 8 * 2**s_offset
) (
	input logic clk,
	input logic rst_n,
	input logic done,
	input dcache_ctrl_pkg::pmem_addr_sel_t addr_sel,
	input logic [s_line-1:0] hit_line,
	input logic [s_offset-3:0] pipe_word_sel,
	input logic [s_tag-1:0] pipe_tag,
	input logic [s_index-1:0] pipe_index,
	input logic [s_tag-1:0] victim_tag,
	output logic resp,
	output rv32_bus_pkg::rv32_word_t resp_rdata,
	output rv32_bus_pkg::rv32_word_t pmem_address
);
	import rv32_bus_pkg::*;
	import dcache_ctrl_pkg::*;

	rv32_word_t sel_word;
	logic [s_tag-1:0] addr_tag;

	assign sel_word = hit_line[32*pipe_word_sel +: 32];

	always_ff @(posedge clk) begin
		if (!rst_n)
			resp <= 1'b0;
		else
			resp <= done;
	end

	always_ff @(posedge clk) begin
		if (done)
			resp_rdata <= sel_word;
	end

	// Line aligned, the set comes from the request either way.
	assign addr_tag = (addr_sel == addr_victim_line) ? victim_tag : pipe_tag;
	assign pmem_address = {addr_tag, pipe_index, {s_offset{1'b0}}};

endmodule : dcache_result

/* rtl/dcache_tag_execute.sv */
module dcache_tag_execute #(
	parameter int s_offset = 5,
	parameter int s_index = 3,
	localparam int s_tag = 32 - s_offset - s_index,
	localparam int s_mask = 2**s_offset,
	localparam int s_line = 8 * s_mask,
	localparam int num_sets = 2**s_index
) (
	input logic clk,
	input logic rst_n,
	input logic [s_index-1:0] rindex,
	input logic [s_index-1:0] pipe_index,
	input logic [s_tag-1:0] pipe_tag,
	input logic array_read,
	input logic store,
	input logic fill,
	input logic lru_touch,
	input logic [s_line-1:0] line_wdata,
	input logic [s_mask-1:0] line_byte_enable,
	input logic [s_line-1:0] pmem_rdata,
	output logic hit,
	output logic victim_dirty,
	output logic [s_tag-1:0] victim_tag,
	output logic [s_line-1:0] hit_line,
	output logic [s_line-1:0] victim_line
);
	logic [s_line-1:0] way_line [2];
	logic [s_tag-1:0] way_tag [2];
	logic [1:0] way_valid;
	logic [1:0] way_dirty;
	logic [1:0] way_hit;
	logic [1:0] is_victim;
	logic [s_mask-1:0] way_data_we [2];
	logic [num_sets-1:0] lru;
	logic lru_way;
	logic [s_line-1:0] line_in;

	assign lru_way = lru[pipe_index];
	assign is_victim = lru_way ? 2'b10 : 2'b01;
	assign line_in = fill ? pmem_rdata : line_wdata;

	for (genvar w = 0; w < 2; w++) begin : g_way
		assign way_hit[w] = way_valid[w] && (way_tag[w] == pipe_tag);

		always_comb begin
			if (fill && is_victim[w])
				way_data_we[w] = '1; // Whole line from memory.
			else if (store && way_hit[w])
				way_data_we[w] = line_byte_enable;
			else
				way_data_we[w] = '0;
		end

		dcache_way_array #(
			.s_offset(s_offset),
			.s_index(s_index)
		) way_inst (
			.clk(clk),
			.rst_n(rst_n),
			.rindex(rindex),
			.windex(pipe_index),
			.read(array_read),
			.data_we(way_data_we[w]),
			.line_in(line_in),
			.tag_we(fill && is_victim[w]),
			.tag_in(pipe_tag),
			.dirty_we((fill && is_victim[w]) || (store && way_hit[w])),
			.dirty_in(store),
			.line_out(way_line[w]),
			.tag_out(way_tag[w]),
			.valid_out(way_valid[w]),
			.dirty_out(way_dirty[w])
		);
	end

	assign hit = |way_hit;
	assign hit_line = way_hit[1] ? way_line[1] : way_line[0];

	// LRU bit names the victim way.
	assign victim_line = way_line[lru_way];
	assign victim_tag = way_tag[lru_way];
	assign victim_dirty = way_valid[lru_way] && way_dirty[lru_way];

	always_ff @(posedge clk) begin
		if (!rst_n)
			lru <= '0;
		else if (lru_touch)
			lru[pipe_index] <= way_hit[0]; // Point at the way that missed.
	end

endmodule : dcache_tag_execute

/* rtl/dcache_top.sv */
module dcache_top #(
	parameter int s_offset = 5,
	parameter int s_index = 3,
	localparam int s_tag = 32 - s_offset - s_index,
	localparam int s_mask = 2**s_offset,
	localparam int s_line = 8 * s_mask
) (
	input logic clk,
	input logic rst_n,
	input logic req,
	input logic req_write,
	input rv32_bus_pkg::rv32_word_t req_address,
	input rv32_bus_pkg::rv32_word_t req_wdata,
	input rv32_bus_pkg::rv32_mask_t req_byte_enable,
	input logic [s_line-1:0] pmem_rdata,
	input logic pmem_resp,
	output logic resp,
	output rv32_bus_pkg::rv32_word_t resp_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output rv32_bus_pkg::rv32_word_t pmem_address,
	output logic [s_line-1:0] pmem_wdata
);
	import dcache_ctrl_pkg::*;

	logic accept;
	logic [s_index-1:0] rindex;
	logic [s_index-1:0] pipe_index;
	logic [s_tag-1:0] pipe_tag;
	logic [s_offset-3:0] pipe_word_sel;
	logic pipe_write;
	logic [s_line-1:0] line_wdata;
	logic [s_mask-1:0] line_byte_enable;
	logic array_read;
	logic store;
	logic fill;
	logic lru_touch;
	logic done;
	pmem_addr_sel_t addr_sel;
	logic hit;
	logic victim_dirty;
	logic [s_tag-1:0] victim_tag;
	logic [s_line-1:0] hit_line;
	logic [s_line-1:0] victim_line;

	assign pmem_wdata = victim_line; // Only sampled during write-back.

	dcache_req_decode #(.s_offset(s_offset), .s_index(s_index)) decode_inst (
		.clk(clk),
		.rst_n(rst_n),
		.accept(accept),
		.req_write(req_write),
		.req_address(req_address),
		.req_wdata(req_wdata),
		.req_byte_enable(req_byte_enable),
		.rindex(rindex),
		.pipe_index(pipe_index),
		.pipe_tag(pipe_tag),
		.pipe_word_sel(pipe_word_sel),
		.pipe_write(pipe_write),
		.line_wdata(line_wdata),
		.line_byte_enable(line_byte_enable)
	);

	dcache_tag_execute #(.s_offset(s_offset), .s_index(s_index)) execute_inst (
		.clk(clk),
		.rst_n(rst_n),
		.rindex(rindex),
		.pipe_index(pipe_index),
		.pipe_tag(pipe_tag),
		.array_read(array_read),
		.store(store),
		.fill(fill),
		.lru_touch(lru_touch),
		.line_wdata(line_wdata),
		.line_byte_enable(line_byte_enable),
		.pmem_rdata(pmem_rdata),
		.hit(hit),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.hit_line(hit_line),
		.victim_line(victim_line)
	);

	dcache_control control_inst (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.pipe_write(pipe_write),
		.hit(hit),
		.victim_dirty(victim_dirty),
		.pmem_resp(pmem_resp),
		.accept(accept),
		.array_read(array_read),
		.store(store),
		.fill(fill),
		.lru_touch(lru_touch),
		.done(done),
		.addr_sel(addr_sel),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write)
	);

	dcache_result #(.s_offset(s_offset), .s_index(s_index)) result_inst (
		.clk(clk),
		.rst_n(rst_n),
		.done(done),
		.addr_sel(addr_sel),
		.hit_line(hit_line),
		.pipe_word_sel(pipe_word_sel),
		.pipe_tag(pipe_tag),
		.pipe_index(pipe_index),
		.victim_tag(victim_tag),
		.resp(resp),
		.resp_rdata(resp_rdata),
		.pmem_address(pmem_address)
	);

endmodule : dcache_top

/* rtl/dcache_way_array.sv */
module dcache_way_array #(
	parameter int s_offset = 5,
	parameter int s_index = 3,
	localparam int s_tag = 32 - s_offset - s_index,
	localparam int s_mask = 2**s_offset,
	localparam int s_line = 8 * s_mask,
	localparam int num_sets = 2**s_index
) (
	input logic clk,
	input logic rst_n,
	input logic [s_index-1:0] rindex,
	input logic [s_index-1:0] windex,
	input logic read,
	input logic [s_mask-1:0] data_we,
	input logic [s_line-1:0] line_in,
	input logic tag_we,
	input logic [s_tag-1:0] tag_in,
	input logic dirty_we,
	input logic dirty_in,
	output logic [s_line-1:0] line_out,
	output logic [s_tag-1:0] tag_out,
	output logic valid_out,
	output logic dirty_out
);
	logic [s_line-1:0] data_mem [num_sets];
	logic [s_tag-1:0] tag_mem [num_sets];
	logic [num_sets-1:0] valid_bits;
	logic [num_sets-1:0] dirty_bits;

	always_ff @(posedge clk) begin
		for (int i = 0; i < s_mask; i++) begin
			if (data_we[i])
				data_mem[windex][8*i +: 8] <= line_in[8*i +: 8];
		end
		if (tag_we)
			tag_mem[windex] <= tag_in;
		if (read) begin // Old contents on a same-set write.
			line_out <= data_mem[rindex];
			tag_out <= tag_mem[rindex];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_bits <= '0;
			dirty_bits <= '0;
			valid_out <= 1'b0;
			dirty_out <= 1'b0;
		end else begin
			if (tag_we)
				valid_bits[windex] <= 1'b1; // A tag write makes the line live.
			if (dirty_we)
				dirty_bits[windex] <= dirty_in;
			if (read) begin
				valid_out <= valid_bits[rindex];
				dirty_out <= dirty_bits[rindex];
			end
		end
	end

endmodule : dcache_way_array

/* rtl/rv32_bus_pkg.sv */
package rv32_bus_pkg;

	// Byte lanes in one bus word.
	localparam int rv32_mask_w = 4;
	localparam int rv32_word_w = 8 * rv32_mask_w;

	// Address or data word on the CPU side.
	typedef logic [rv32_word_w-1:0] rv32_word_t;

	typedef logic [rv32_mask_w-1:0] rv32_mask_t; // One enable bit per byte.

endpackage : rv32_bus_pkg

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module dcache_tb

./obj_dir/Vdcache_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation finished without failure"

/* test/dcache_chk.sv */
module dcache_chk (
	input logic clk,
	input logic rst_n,
	input logic req,
	input logic done,
	input logic pmem_read,
	input logic pmem_write,
	input dcache_ctrl_pkg::dcache_state_t state
);
	import dcache_ctrl_pkg::*;

	int fail_count = 0;

	// Done is registered straight into resp.
	resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else begin
			$error("resp held high for more than one cycle");
			fail_count++;
		end

	pmem_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write))
		else begin
			$error("pmem_read and pmem_write high together");
			fail_count++;
		end

	req_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
		req |-> state == st_idle)
		else begin
			$error("req arrived while the cache was busy");
			fail_count++;
		end

	read_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
		pmem_read |-> state == st_fill)
		else begin
			$error("pmem_read outside the fill state");
			fail_count++;
		end

	write_in_writeback: assert property (@(posedge clk) disable iff (!rst_n)
		pmem_write |-> state == st_writeback)
		else begin
			$error("pmem_write outside the writeback state");
			fail_count++;
		end

endmodule : dcache_chk

bind dcache_control dcache_chk chk_inst (
	.clk(clk),
	.rst_n(rst_n),
	.req(req),
	.done(done),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.state(state)
);

/* test/dcache_golden.txt */
// Each line holds op addr wdata mask rdata miss writeback in hex.
// Op 1 is a write and its rdata column is not checked.
0 00000024 00000000 f c0de0024 1 0
0 00000028 00000000 f c0de0028 0 0
1 00000024 aabbccdd 5 00000000 0 0
0 00000024 00000000 f c0bb00dd 0 0
1 00000048 12345678 c 00000000 1 0
0 00000048 00000000 f 12340048 0 0
0 0000004c 00000000 f c0de004c 0 0
0 00000120 00000000 f c0de0120 1 0
0 00000024 00000000 f c0bb00dd 0 0
0 00000224 00000000 f c0de0224 1 0
0 00000120 00000000 f c0de0120 1 1
0 00000024 00000000 f c0bb00dd 1 0
0 00000148 00000000 f c0de0148 1 0
0 00000248 00000000 f c0de0248 1 1
0 00000048 00000000 f 12340048 1 0
1 0000004c deadbeef f 00000000 0 0
0 0000004c 00000000 f deadbeef 0 0
1 0000003c 0000face 3 00000000 0 0
0 0000003c 00000000 f c0deface 0 0

/* test/dcache_scoreboard.sv */
module dcache_scoreboard (
	input logic clk,
	input logic rst_n,
	input logic req,
	input logic req_write,
	input rv32_bus_pkg::rv32_word_t req_address,
	input logic resp,
	input rv32_bus_pkg::rv32_word_t resp_rdata,
	input logic pmem_read,
	input logic pmem_write,
	input rv32_bus_pkg::rv32_word_t exp_rdata,
	input logic exp_miss,
	input logic exp_wb,
	output int passed,
	output int failed
);
	import rv32_bus_pkg::*;

	rv32_word_t want_rdata;
	rv32_word_t addr_q;
	logic want_miss;
	logic want_wb;
	logic is_write;
	logic busy;
	int reads;
	int writes;
	int latency;
	int req_num;
	string msg;

	always @(posedge clk) begin
		if (!rst_n) begin
			busy = 1'b0;
			passed = 0;
			failed = 0;
			req_num = 0;
		end else begin
			if (busy) begin
				latency++; // Edges since the req edge.
				if (pmem_read)
					reads++;
				if (pmem_write)
					writes++;
			end
			if (req) begin
				busy = 1'b1;
				want_rdata = exp_rdata;
				want_miss = exp_miss;
				want_wb = exp_wb;
				is_write = req_write;
				addr_q = req_address;
				reads = 0;
				writes = 0;
				latency = 0;
			end else if (busy && resp) begin
				busy = 1'b0;
				msg = "";
				if (!is_write && resp_rdata !== want_rdata)
					msg = $sformatf("read data %h, expected %h", resp_rdata, want_rdata);
				else if (reads != int'(want_miss))
					msg = $sformatf("%0d line fills, expected %0d", reads, want_miss);
				else if (writes != int'(want_wb))
					msg = $sformatf("%0d write-backs, expected %0d", writes, want_wb);
				else if (!want_miss && latency != 2)
					msg = $sformatf("hit answered after %0d cycles, expected 2", latency);
				if (msg == "") begin
					passed++;
					$display("pass %0t: request %0d %s %h", $time, req_num,
						is_write ? "write" : "read", addr_q);
				end else begin
					failed++;
					$display("FAIL %0t: request %0d at %h %s", $time, req_num, addr_q, msg);
				end
				req_num++;
			end
		end
	end

endmodule : dcache_scoreboard

/* test/dcache_tb.sv */
module dcache_tb;
	import rv32_bus_pkg::*;

	localparam int s_offset = 5;
	localparam int s_index = 3;
	localparam int s_line = 8 * 2**s_offset;
	localparam int line_words = s_line / 32;
	localparam int mem_words = 4096;
	localparam int max_reqs = 32;
	localparam int resp_timeout = 200;

	logic clk;
	logic rst_n;
	logic req;
	logic req_write;
	rv32_word_t req_address;
	rv32_word_t req_wdata;
	rv32_mask_t req_byte_enable;
	logic [s_line-1:0] pmem_rdata;
	logic pmem_resp;
	logic resp;
	rv32_word_t resp_rdata;
	logic pmem_read;
	logic pmem_write;
	rv32_word_t pmem_address;
	logic [s_line-1:0] pmem_wdata;

	rv32_word_t exp_rdata;
	logic exp_miss;
	logic exp_wb;
	int passed;
	int failed;

	rv32_word_t golden [256];
	rv32_word_t mem [mem_words];
	int issued;
	bit timed_out;

	dcache_top #(.s_offset(s_offset), .s_index(s_index)) dcache_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.req_write(req_write),
		.req_address(req_address),
		.req_wdata(req_wdata),
		.req_byte_enable(req_byte_enable),
		.pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp),
		.resp(resp),
		.resp_rdata(resp_rdata),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata)
	);

	dcache_scoreboard scoreboard_inst (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.req_write(req_write),
		.req_address(req_address),
		.resp(resp),
		.resp_rdata(resp_rdata),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.exp_rdata(exp_rdata),
		.exp_miss(exp_miss),
		.exp_wb(exp_wb),
		.passed(passed),
		.failed(failed)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Line-wide memory answering each strobe after 2 to 6 cycles.
	initial begin : memory_model
		int lat;
		logic [11:0] word_idx;
		logic write_op;
		logic [s_line-1:0] line;
		void'($urandom(32'h9129));
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		for (int i = 0; i < mem_words; i++)
			mem[i[11:0]] = rv32_word_t'(4 * i) ^ 32'hC0DE0000;
		forever begin
			@(posedge clk);
			#1;
			pmem_resp = 1'b0;
			if (pmem_read || pmem_write) begin
				write_op = pmem_write;
				line = pmem_wdata;
				word_idx = pmem_address[13:2];
				lat = 2 + int'($urandom % 5);
				repeat (lat) @(posedge clk);
				#1;
				for (int w = 0; w < line_words; w++) begin
					if (write_op)
						mem[word_idx + 12'(w)] = line[32*w +: 32];
					else
						pmem_rdata[32*w +: 32] = mem[word_idx + 12'(w)];
				end
				pmem_resp = 1'b1;
			end
		end
	end

	// One strobe and a bounded wait for resp.
	task automatic send_request(input logic [7:0] base, input int n, output bit no_resp);
		int wait_cycles;
		@(posedge clk);
		#1;
		req = 1'b1;
		req_write = golden[base][0];
		req_address = golden[base + 8'd1];
		req_wdata = golden[base + 8'd2];
		req_byte_enable = golden[base + 8'd3][3:0];
		exp_rdata = golden[base + 8'd4];
		exp_miss = golden[base + 8'd5][0];
		exp_wb = golden[base + 8'd6][0];
		@(posedge clk);
		#1;
		req = 1'b0;
		wait_cycles = 0;
		while (!resp && wait_cycles < resp_timeout) begin
			@(posedge clk);
			#1;
			wait_cycles++;
		end
		no_resp = !resp;
		if (no_resp)
			$display("Request %0d got no response within %0d cycles", n, resp_timeout);
	endtask

	initial begin : stimulus
		int n;
		bit no_resp;
		rst_n = 1'b0;
		req = 1'b0;
		req_write = 1'b0;
		req_address = '0;
		req_wdata = '0;
		req_byte_enable = '0;
		exp_rdata = '0;
		exp_miss = 1'b0;
		exp_wb = 1'b0;
		timed_out = 1'b0;
		for (int i = 0; i < 256; i++)
			golden[i[7:0]] = '1; // All ones marks the end of the list.
		$readmemh("test/dcache_golden.txt", golden);
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		n = 0;
		while (n < max_reqs && golden[8'(7 * n)] != '1 && !timed_out) begin
			send_request(8'(7 * n), n, no_resp);
			timed_out = no_resp;
			n++;
		end
		issued = n;
		repeat (2) @(posedge clk);
		if (issued == 0)
			$display("No requests were read from test/dcache_golden.txt");
		if (dcache_top_inst.control_inst.chk_inst.fail_count != 0)
			$display("Protocol assertions failed %0d times",
				dcache_top_inst.control_inst.chk_inst.fail_count);
		$display("Totals: %0d requests, %0d passed, %0d failed", issued, passed, failed);
		if (timed_out || issued == 0 || failed != 0 || passed != issued
			|| dcache_top_inst.control_inst.chk_inst.fail_count != 0)
			$display("STATUS: FAIL");
		else
			$display("STATUS: PASS");
		$finish;
	end

endmodule : dcache_tb

/* verilog.f */
rtl/rv32_bus_pkg.sv
rtl/dcache_ctrl_pkg.sv
rtl/dcache_req_decode.sv
rtl/dcache_way_array.sv
rtl/dcache_tag_execute.sv
rtl/dcache_control.sv
rtl/dcache_result.sv
rtl/dcache_top.sv
test/dcache_chk.sv
test/dcache_scoreboard.sv
test/dcache_tb.sv
